//--- rtl/spd_pkg.sv
package spd_pkg;

    localparam int I2C_ADDR_W = 7;
    typedef logic [I2C_ADDR_W-1:0] i2c_addr_t;

    localparam i2c_addr_t SCAN_FIRST_ADDR = 7'd1; // 0 is the general call

    // one SPD byte, seen through the field layout of the byte being decoded
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic       rsvd;
            logic [2:0] bank_bits;
            logic [3:0] capacity;
        } density;                  // byte 4
        struct packed {
            logic [1:0] rsvd;
            logic [2:0] row;
            logic [2:0] col;
        } addressing;               // byte 5
        struct packed {
            logic [1:0] rsvd;
            logic [2:0] ranks;
            logic [2:0] dev_width;
        } org;                      // bytes 7 and 8
    } spd_byte_u;

    localparam int SPD_IDX_START      = 0;
    localparam int SPD_IDX_REVISION   = 1;
    localparam int SPD_IDX_DRAM_TYPE  = 2;
    localparam int SPD_IDX_MODULE     = 3;
    localparam int SPD_IDX_DENSITY    = 4;
    localparam int SPD_IDX_ADDRESSING = 5;
    localparam int SPD_IDX_ORG        = 7;
    localparam int SPD_IDX_BUS_WIDTH  = 8;
    localparam int SPD_IDX_TRCD       = 18;
    localparam int SPD_IDX_TRP        = 20;
    localparam int SPD_IDX_TRAS_HI    = 21; // upper nibbles of tRAS and tRC
    localparam int SPD_IDX_TRAS       = 22;

    localparam logic [7:0] DDR3_DEVICE_TYPE = 8'h0B;

    localparam int LINE_CHARS = 30;
    typedef logic [LINE_CHARS*8-1:0] text_line_t; // first char in the top byte
    typedef logic [4:0] line_len_t;

    function automatic logic [7:0] hex_char(input logic [3:0] nib);
        return (nib < 4'd10) ? 8'h30 + 8'(nib) : 8'h37 + 8'(nib);
    endfunction

endpackage

//--- rtl/spd_ifs.sv
`timescale 1ns/1ps

// found address or SPD byte, handed from sequencer to formatter
interface spd_item_if import spd_pkg::*; #(parameter int IDX_W = 6);
    logic             item_valid;   // one-cycle strobe
    logic             item_is_addr;
    logic [IDX_W-1:0] item_index;
    i2c_addr_t        item_addr;
    spd_byte_u        item_data;
    logic             item_done;    // line sent, or no line for this item

    modport seq (output item_valid, item_is_addr, item_index, item_addr, item_data,
                 input item_done);
    modport fmt (input item_valid, item_is_addr, item_index, item_addr, item_data,
                 output item_done);
endinterface

interface text_line_if import spd_pkg::*;;
    logic       line_start;
    text_line_t line_text;
    line_len_t  line_len;
    logic       line_done;

    modport src (output line_start, line_text, line_len, input line_done);
    modport snk (input line_start, line_text, line_len, output line_done);
endinterface

//--- rtl/spd_sequencer.sv
`timescale 1ns/1ps

module spd_sequencer import spd_pkg::*; #(
    parameter int N_SPD_BYTES = 64
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    output logic       o_i2c_en,
    output i2c_addr_t  o_i2c_dev_addr,
    output logic [7:0] o_i2c_reg_addr,
    input  logic [7:0] i_i2c_rdata,
    input  logic       i_i2c_busy,
    input  logic       i_i2c_nack,
    spd_item_if.seq    item,
    output logic       o_addr_found,
    output logic       o_read_done,
    output logic       o_nack_err
);

    localparam int IDX_W = (N_SPD_BYTES > 1) ? $clog2(N_SPD_BYTES) : 1;

    // scan states first, then the byte read states
    typedef enum logic [2:0] {
        S_SCAN_REQ, S_SCAN_WAIT, S_READ_REQ, S_READ_WAIT, S_ITEM_WAIT, S_DONE
    } state_t;

    state_t           state;
    i2c_addr_t        scan_addr;
    logic [IDX_W-1:0] byte_idx;

    // result is valid once the strobe is gone and busy has fallen again
    wire i2c_result = !o_i2c_en && !i_i2c_busy;

    assign item.item_index = byte_idx;
    assign item.item_addr  = scan_addr;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state             <= S_SCAN_REQ;
            scan_addr         <= SCAN_FIRST_ADDR;
            byte_idx          <= '0;
            o_i2c_en          <= 1'b0;
            item.item_valid   <= 1'b0;
            item.item_is_addr <= 1'b0;
            o_addr_found      <= 1'b0;
            o_read_done       <= 1'b0;
            o_nack_err        <= 1'b0;
        end else begin
            o_i2c_en        <= 1'b0;
            item.item_valid <= 1'b0;
            case (state)
                S_SCAN_REQ: if (!i_i2c_busy) begin
                    o_i2c_en <= 1'b1;
                    state    <= S_SCAN_WAIT;
                end
                S_SCAN_WAIT: if (i2c_result) begin
                    if (i_i2c_nack) begin
                        scan_addr <= (scan_addr == '1) ? SCAN_FIRST_ADDR : scan_addr + 1'b1;
                        state     <= S_SCAN_REQ;
                    end else begin
                        item.item_is_addr <= 1'b1;
                        item.item_valid   <= 1'b1;
                        state             <= S_ITEM_WAIT;
                    end
                end
                S_READ_REQ: if (!i_i2c_busy) begin
                    o_i2c_en <= 1'b1;
                    state    <= S_READ_WAIT;
                end
                S_READ_WAIT: if (i2c_result) begin
                    if (i_i2c_nack) begin
                        o_nack_err <= 1'b1; // device vanished mid-read
                        state      <= S_DONE;
                    end else begin
                        item.item_is_addr <= 1'b0;
                        item.item_valid   <= 1'b1;
                        state             <= S_ITEM_WAIT;
                    end
                end
                S_ITEM_WAIT: if (item.item_done) begin
                    if (item.item_is_addr) begin
                        o_addr_found <= 1'b1;
                        byte_idx     <= '0;
                        state        <= S_READ_REQ;
                    end else if (byte_idx == IDX_W'(N_SPD_BYTES - 1)) begin
                        o_read_done <= 1'b1;
                        state       <= S_DONE;
                    end else begin
                        byte_idx <= byte_idx + 1'b1;
                        state    <= S_READ_REQ;
                    end
                end
                default: state <= S_DONE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == S_SCAN_REQ || state == S_READ_REQ) begin
            o_i2c_dev_addr <= scan_addr;
            o_i2c_reg_addr <= (state == S_SCAN_REQ) ? 8'h00 : 8'(byte_idx);
        end
        if (state == S_READ_WAIT && i2c_result) begin
            item.item_data <= i_i2c_rdata;
        end
    end

endmodule

//--- rtl/spd_line_formatter.sv
`timescale 1ns/1ps

module spd_line_formatter import spd_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst_n,
    spd_item_if.fmt item,
    text_line_if.src line
);

    localparam logic [7:0] LF = 8'h0A;

    spd_byte_u   data;
    text_line_t  body;      // right-aligned text of the line
    line_len_t   body_len;
    logic        has_line;
    logic [15:0] row_txt;
    logic [15:0] col_txt;
    logic [3:0]  tras_hi;
    logic        wait_line;

    assign data = item.item_data;

    always_comb begin
        body     = '0;
        body_len = '0;
        has_line = 1'b1;
        row_txt  = (data.addressing.row > 3'd4) ? "??" : {"1", "2" + 8'(data.addressing.row)};
        if (data.addressing.col == 3'd0)
            col_txt = "9 ";
        else if (data.addressing.col > 3'd3)
            col_txt = "??";
        else
            col_txt = {"1", "0" + 8'(data.addressing.col - 3'd1)};

        if (item.item_is_addr) begin
            body = {"I2C Address: 0x", hex_char({1'b0, item.item_addr[6:4]}),
                    hex_char(item.item_addr[3:0]), LF};
            body_len = 5'd18;
        end else begin
            case (item.item_index)
                SPD_IDX_START: begin
                    body     = {"START SPD READ", LF};
                    body_len = 5'd15;
                end
                SPD_IDX_REVISION: begin
                    body = {"SPD Revision: ", hex_char(data.raw[7:4]), ".",
                            hex_char(data.raw[3:0]), LF};
                    body_len = 5'd18;
                end
                SPD_IDX_DRAM_TYPE: if (data.raw == DDR3_DEVICE_TYPE) begin
                    body     = {"DRAM Type: DDR3 SDRAM", LF};
                    body_len = 5'd22;
                end else begin
                    body     = {"DRAM Type: NOT DDR3!", LF};
                    body_len = 5'd21;
                end
                SPD_IDX_MODULE: case (data.raw)
                    8'h00: {body, body_len} = {text_line_t'({"Module Type: Undefined!", LF}), 5'd24};
                    8'h01: {body, body_len} = {text_line_t'({"Module Type: RDIMM", LF}), 5'd19};
                    8'h02: {body, body_len} = {text_line_t'({"Module Type: UDIMM", LF}), 5'd19};
                    8'h03: {body, body_len} = {text_line_t'({"Module Type: SO-DIMM", LF}), 5'd21};
                    default: has_line = 1'b0; // reserved module types
                endcase
                SPD_IDX_DENSITY: begin
                    body = {"BA_BITS: ", hex_char(4'(data.density.bank_bits) + 4'd3), LF,
                            "SDRAM_CAPACITY: ", hex_char(data.density.capacity), LF};
                    body_len = 5'd29;
                end
                SPD_IDX_ADDRESSING: begin
                    body     = {"ROW_BITS: ", row_txt, LF, "COL_BITS: ", col_txt, LF};
                    body_len = 5'd26;
                end
                SPD_IDX_ORG: begin
                    body     = {"DUAL_RANK_DIMM: ", (data.org.ranks == 3'd1) ? "1" : "0", LF};
                    body_len = 5'd18;
                end
                SPD_IDX_BUS_WIDTH: if (data.org.dev_width <= 3'd3) begin
                    body     = {"BYTE_LANES: ", "0" + (8'd1 << data.org.dev_width), LF};
                    body_len = 5'd14;
                end else begin
                    has_line = 1'b0;
                end
                SPD_IDX_TRCD: begin
                    body = {"TRCD: mtb * 0x", hex_char(data.raw[7:4]), hex_char(data.raw[3:0]), LF};
                    body_len = 5'd17;
                end
                SPD_IDX_TRP: begin
                    body = {"TRP: mtb * 0x", hex_char(data.raw[7:4]), hex_char(data.raw[3:0]), LF};
                    body_len = 5'd16;
                end
                SPD_IDX_TRAS: begin
                    body = {"TRAS: mtb * 0x", hex_char(tras_hi), hex_char(data.raw[7:4]),
                            hex_char(data.raw[3:0]), LF};
                    body_len = 5'd18;
                end
                default: has_line = 1'b0;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wait_line       <= 1'b0;
            line.line_start <= 1'b0;
            item.item_done  <= 1'b0;
        end else begin
            line.line_start <= 1'b0;
            item.item_done  <= 1'b0;
            if (item.item_valid) begin
                line.line_start <= has_line;
                wait_line       <= has_line;
                item.item_done  <= !has_line; // nothing to print
            end else if (wait_line && line.line_done) begin
                wait_line      <= 1'b0;
                item.item_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (item.item_valid) begin
            line.line_text <= body << (8 * (LINE_CHARS - int'(body_len))); // left-justify
            line.line_len  <= body_len;
            if (!item.item_is_addr && item.item_index == SPD_IDX_TRAS_HI)
                tras_hi <= data.raw[3:0];
        end
    end

endmodule

//--- rtl/uart_line_sender.sv
`timescale 1ns/1ps

module uart_line_sender import spd_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    text_line_if.snk   line,
    output logic       o_tx_en,
    output logic [7:0] o_tx_data,
    input  logic       i_tx_busy
);

    typedef enum logic [1:0] {S_IDLE, S_SEND, S_WAIT} state_t;

    state_t     state;
    text_line_t text_q;
    line_len_t  chars_left;

    assign o_tx_data = text_q[LINE_CHARS*8-1 -: 8]; // current char sits at the top

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state          <= S_IDLE;
            chars_left     <= '0;
            o_tx_en        <= 1'b0;
            line.line_done <= 1'b0;
        end else begin
            line.line_done <= 1'b0;
            case (state)
                S_IDLE: if (line.line_start) begin
                    chars_left <= line.line_len;
                    state      <= S_SEND;
                end
                S_SEND: if (i_tx_busy) begin
                    o_tx_en <= 1'b0;    // char accepted
                    state   <= S_WAIT;
                end else begin
                    o_tx_en <= 1'b1;
                end
                S_WAIT: if (!i_tx_busy) begin
                    chars_left <= chars_left - 1'b1;
                    if (chars_left == 5'd1) begin
                        line.line_done <= 1'b1;
                        state          <= S_IDLE;
                    end else begin
                        state <= S_SEND;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == S_IDLE && line.line_start)
            text_q <= line.line_text;
        else if (state == S_WAIT && !i_tx_busy)
            text_q <= text_q << 8;
    end

endmodule

//--- rtl/spd_reader_top.sv
`timescale 1ns/1ps

module spd_reader_top import spd_pkg::*; #(
    parameter int N_SPD_BYTES = 64
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    output logic       o_i2c_en,
    output i2c_addr_t  o_i2c_dev_addr,
    output logic [7:0] o_i2c_reg_addr,
    input  logic [7:0] i_i2c_rdata,
    input  logic       i_i2c_busy,
    input  logic       i_i2c_nack,
    output logic       o_tx_en,
    output logic [7:0] o_tx_data,
    input  logic       i_tx_busy,
    output logic       o_addr_found,
    output logic       o_read_done,
    output logic       o_nack_err
);

    localparam int IDX_W = (N_SPD_BYTES > 1) ? $clog2(N_SPD_BYTES) : 1;

    spd_item_if #(.IDX_W(IDX_W)) item_bus ();
    text_line_if                 line_bus ();

    spd_sequencer #(.N_SPD_BYTES(N_SPD_BYTES)) u_sequencer (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .o_i2c_en       (o_i2c_en),
        .o_i2c_dev_addr (o_i2c_dev_addr),
        .o_i2c_reg_addr (o_i2c_reg_addr),
        .i_i2c_rdata    (i_i2c_rdata),
        .i_i2c_busy     (i_i2c_busy),
        .i_i2c_nack     (i_i2c_nack),
        .item           (item_bus.seq),
        .o_addr_found   (o_addr_found),
        .o_read_done    (o_read_done),
        .o_nack_err     (o_nack_err)
    );

    spd_line_formatter u_formatter (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .item    (item_bus.fmt),
        .line    (line_bus.src)
    );

    uart_line_sender u_sender (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .line      (line_bus.snk),
        .o_tx_en   (o_tx_en),
        .o_tx_data (o_tx_data),
        .i_tx_busy (i_tx_busy)
    );

endmodule

//--- tests/spd_checker.sv
`timescale 1ns/1ps

module spd_checker (
    input logic       i_clk,
    input logic       i_rst_n,
    input logic       i_i2c_en,
    input logic [6:0] i_i2c_dev_addr,
    input logic [7:0] i_i2c_reg_addr,
    input logic       i_i2c_busy,
    input logic       i_tx_en,
    input logic [7:0] i_tx_data,
    input logic       i_tx_busy,
    input logic       i_addr_found,
    input logic       i_read_done,
    input logic       i_nack_err
);

    string exp_q[$];
    string cur;         // characters since the last LF
    string test_name;
    int    lines_seen;
    int    test_errs;
    int    n_pass = 0;
    int    n_fail = 0;
    logic  found_q;
    logic [6:0] exp_dev;
    logic [6:0] scan_next;  // next address the scan should try
    logic [7:0] reg_next;   // next SPD byte the read should ask for

    task automatic start_test(input string name, input logic [6:0] dev);
        test_name  = name;
        exp_dev    = dev;
        test_errs  = 0;
        lines_seen = 0;
        cur        = "";
        exp_q.delete();
    endtask

    task automatic add_expected(input string s);
        exp_q.push_back(s);
    endtask

    task automatic compare_line(input string got);
        string want;
        if (exp_q.size() == 0) begin
            $display("%0t: test %s sent an extra line \"%s\"", $time, test_name, got);
            test_errs++;
        end else begin
            want = exp_q.pop_front();
            if (got != want) begin
                $display("[ERROR] %0t o_tx_data line: expected \"%s\" got \"%s\"",
                         $time, want, got);
                test_errs++;
            end
        end
        lines_seen++;
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("[ERROR] %0t %s: expected %0b got %0b", $time, name, want, got);
            test_errs++;
        end
    endtask

    // scan goes upward from 1 with register 0, then bytes from 0 at the found address
    task automatic check_i2c_req();
        logic [6:0] want_dev;
        logic [7:0] want_reg;
        if (i_i2c_busy) begin
            $display("%0t: test %s issued an I2C request while the master was busy",
                     $time, test_name);
            test_errs++;
        end
        if (i_addr_found) begin
            want_dev = exp_dev;
            want_reg = reg_next;
            reg_next = reg_next + 8'd1;
        end else begin
            want_dev  = scan_next;
            want_reg  = 8'h00;
            scan_next = scan_next + 7'd1;
        end
        if (i_i2c_dev_addr !== want_dev) begin
            $display("[ERROR] %0t o_i2c_dev_addr: expected %h got %h",
                     $time, want_dev, i_i2c_dev_addr);
            test_errs++;
        end
        if (i_i2c_reg_addr !== want_reg) begin
            $display("[ERROR] %0t o_i2c_reg_addr: expected %h got %h",
                     $time, want_reg, i_i2c_reg_addr);
            test_errs++;
        end
    endtask

    task automatic finish_test(input logic exp_found, input logic exp_done, input logic exp_nack);
        check_flag("o_addr_found", i_addr_found, exp_found);
        check_flag("o_read_done", i_read_done, exp_done);
        check_flag("o_nack_err", i_nack_err, exp_nack);
        if (exp_q.size() != 0) begin
            $display("%0t: test %s never sent %0d expected lines", $time, test_name,
                     exp_q.size());
            test_errs++;
        end
        if (cur.len() != 0) begin
            $display("%0t: test %s left a line without LF \"%s\"", $time, test_name, cur);
            test_errs++;
        end
        if (test_errs == 0) begin
            n_pass++;
            $display("test %s: ok, %0d lines", test_name, lines_seen);
        end else begin
            n_fail++;
            $display("test %s: failed with %0d errors", test_name, test_errs);
        end
    endtask

    // a char is taken on the edge where tx_en meets an idle uart
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            cur       = "";
            found_q   = 1'b0;
            scan_next = 7'd1;
            reg_next  = 8'd0;
        end else begin
            if (i_addr_found && !found_q && lines_seen == 0) begin
                $display("%0t: o_addr_found rose before the address line", $time);
                test_errs++;
            end
            found_q = i_addr_found;
            if (i_i2c_en)
                check_i2c_req();
            if (i_tx_en && !i_tx_busy) begin
                if (i_tx_data == 8'h0A) begin
                    compare_line(cur);
                    cur = "";
                end else begin
                    cur = $sformatf("%s%c", cur, i_tx_data);
                end
            end
        end
    end

endmodule

//--- tests/tb_spd_reader.sv
`timescale 1ns/1ps

module tb_spd_reader;

    localparam int N_BYTES         = 24;
    localparam int MAX_TESTS       = 8;
    localparam int I2C_BUSY_CYCLES = 5;
    localparam int TX_BUSY_CYCLES  = 4;
    localparam int QUIET_CYCLES    = 60;   // window for stray lines after the flags

    logic       clk;
    logic       rst_n;
    logic       i2c_en;
    logic [6:0] i2c_dev_addr;
    logic [7:0] i2c_reg_addr;
    logic [7:0] i2c_rdata;
    logic       i2c_busy;
    logic       i2c_nack;
    logic       tx_en;
    logic [7:0] tx_data;
    logic       tx_busy;
    logic       addr_found;
    logic       read_done;
    logic       nack_err;

    logic [7:0] spd_mem [0:MAX_TESTS*N_BYTES-1];
    string      names [MAX_TESTS];
    logic [6:0] addrs [MAX_TESTS];
    int         nacks [MAX_TESTS];    // -1 when the device never NACKs a byte
    int         exp_base [MAX_TESTS];
    int         exp_cnt [MAX_TESTS];
    string      exp_all[$];
    int         n_tests;
    int         cur_test;
    int         i2c_left;
    int         tx_left;
    logic [6:0] req_dev;
    logic [7:0] req_reg;
    int         cycles;
    int         cycle_limit;
    bit         running;
    bit         load_ok;

    spd_reader_top #(.N_SPD_BYTES(N_BYTES)) dut (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .o_i2c_en       (i2c_en),
        .o_i2c_dev_addr (i2c_dev_addr),
        .o_i2c_reg_addr (i2c_reg_addr),
        .i_i2c_rdata    (i2c_rdata),
        .i_i2c_busy     (i2c_busy),
        .i_i2c_nack     (i2c_nack),
        .o_tx_en        (tx_en),
        .o_tx_data      (tx_data),
        .i_tx_busy      (tx_busy),
        .o_addr_found   (addr_found),
        .o_read_done    (read_done),
        .o_nack_err     (nack_err)
    );

    spd_checker chk (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_i2c_en       (i2c_en),
        .i_i2c_dev_addr (i2c_dev_addr),
        .i_i2c_reg_addr (i2c_reg_addr),
        .i_i2c_busy     (i2c_busy),
        .i_tx_en        (tx_en),
        .i_tx_data      (tx_data),
        .i_tx_busy      (tx_busy),
        .i_addr_found   (addr_found),
        .i_read_done    (read_done),
        .i_nack_err     (nack_err)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // i2c slave: busy from the cycle after the strobe, result when busy falls
    always @(posedge clk) begin
        if (i2c_en) begin
            req_dev  = i2c_dev_addr;
            req_reg  = i2c_reg_addr;
            i2c_left = I2C_BUSY_CYCLES;
            #1 i2c_busy = 1'b1;
        end else if (i2c_left > 0) begin
            i2c_left = i2c_left - 1;
            if (i2c_left == 0) begin
                #1;
                i2c_nack  = (req_dev != addrs[cur_test]) || (int'(req_reg) == nacks[cur_test]);
                i2c_rdata = i2c_nack ? 8'hFF : spd_mem[cur_test*N_BYTES + int'(req_reg)];
                i2c_busy  = 1'b0;
            end
        end
    end

    // uart: busy for a fixed time per character
    always @(posedge clk) begin
        if (tx_en && !tx_busy) begin
            tx_left = TX_BUSY_CYCLES;
            #1 tx_busy = 1'b1;
        end else if (tx_left > 0) begin
            tx_left = tx_left - 1;
            if (tx_left == 0) begin
                #1 tx_busy = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (running) begin
            cycles++;
            if (cycles > cycle_limit) begin
                $display("run stalled: no result after %0d cycles", cycles);
                $display("=== FAIL ===");
                $finish;
            end
        end
    end

    function automatic string strip_eol(input string s);
        string r;
        r = s;
        while (r.len() > 0 && (r[r.len()-1] == 8'h0A || r[r.len()-1] == 8'h0D))
            r = r.substr(0, r.len() - 2);
        return r;
    endfunction

    // next line that is neither blank nor a comment
    task automatic next_line(input int fd, output string s, output bit ok);
        string raw;
        int    n;
        ok = 1'b0;
        s  = "";
        while (!ok && !$feof(fd)) begin
            n = $fgets(raw, fd);
            s = strip_eol(raw);
            if (n != 0 && s.len() != 0 && s[0] != "#")
                ok = 1'b1;
        end
    endtask

    task automatic load_stim(output bit ok);
        int    fd;
        int    addr;
        int    b;
        bit    got;
        string line;
        string name;
        string nack_str;
        n_tests = 0;
        fd = $fopen("tests/spd_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/spd_stim.txt");
        end else begin
            next_line(fd, line, got);
            while (got && n_tests < MAX_TESTS) begin
                void'($sscanf(line, "%s %h %s", name, addr, nack_str));
                names[n_tests] = name;
                addrs[n_tests] = addr[6:0];
                if (nack_str == "none")
                    nacks[n_tests] = -1;
                else
                    void'($sscanf(nack_str, "%d", nacks[n_tests]));
                for (int i = 0; i < N_BYTES; i++) begin
                    void'($fscanf(fd, "%h", b));
                    spd_mem[n_tests*N_BYTES + i] = b[7:0];
                end
                exp_base[n_tests] = exp_all.size();
                exp_cnt[n_tests]  = 0;
                next_line(fd, line, got);
                while (got && line != "end") begin
                    exp_all.push_back(line);
                    exp_cnt[n_tests]++;
                    next_line(fd, line, got);
                end
                n_tests++;
                next_line(fd, line, got);
            end
            $fclose(fd);
        end
        ok = (n_tests > 0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n     = 1'b0;
        i2c_busy  = 1'b0;
        i2c_nack  = 1'b0;
        i2c_rdata = 8'h00;
        tx_busy   = 1'b0;
        i2c_left  = 0;
        tx_left   = 0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    task automatic run_test(input int t);
        cur_test = t;
        chk.start_test(names[t], addrs[t]);
        for (int i = 0; i < exp_cnt[t]; i++)
            chk.add_expected(exp_all[exp_base[t] + i]);
        apply_reset();
        while (!(read_done || nack_err))
            @(posedge clk);
        repeat (QUIET_CYCLES) @(posedge clk);
        chk.finish_test(1'b1, nacks[t] < 0, nacks[t] >= 0);
    endtask

    initial begin
        rst_n     = 1'b0;
        i2c_rdata = 8'h00;
        i2c_busy  = 1'b0;
        i2c_nack  = 1'b0;
        tx_busy   = 1'b0;
        cur_test  = 0;
        i2c_left  = 0;
        tx_left   = 0;
        cycles    = 0;
        running   = 1'b0;
        load_stim(load_ok);
        if (!load_ok) begin
            $display("no usable test in tests/spd_stim.txt");
            $display("=== FAIL ===");
        end else begin
            cycle_limit = 0;
            for (int t = 0; t < n_tests; t++)
                cycle_limit += 200 * exp_cnt[t] + 40 * N_BYTES;
            running = 1'b1;
            for (int t = 0; t < n_tests; t++)
                run_test(t);
            $display("tests passed: %0d, failed: %0d", chk.n_pass, chk.n_fail);
            if (chk.n_fail == 0)
                $display("=== PASS ===");
            else
                $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- build.f
rtl/spd_pkg.sv
rtl/spd_ifs.sv
rtl/spd_sequencer.sv
rtl/spd_line_formatter.sv
rtl/uart_line_sender.sv
rtl/spd_reader_top.sv
tests/spd_checker.sv
tests/tb_spd_reader.sv

//--- Bender.yml
package:
  name: spd_reader

sources:
  - rtl/spd_pkg.sv
  - rtl/spd_ifs.sv
  - rtl/spd_sequencer.sv
  - rtl/spd_line_formatter.sv
  - rtl/uart_line_sender.sv
  - rtl/spd_reader_top.sv
  - target: test
    files:
      - tests/spd_checker.sv
      - tests/tb_spd_reader.sv

//--- tests/spd_stim.txt
# header: <test name> <device address, hex> <NACK byte index, decimal, or none>
# then 24 SPD bytes in hex, then the expected UART lines, closed by a line "end"
sodimm 50 none
92 10 0B 03 03 19 00 09 03 11 01 08 0C 00 7E 00 69 78 69 30 69 11 18 20
I2C Address: 0x50
START SPD READ
SPD Revision: 1.0
DRAM Type: DDR3 SDRAM
Module Type: SO-DIMM
BA_BITS: 3
SDRAM_CAPACITY: 3
ROW_BITS: 15
COL_BITS: 10
DUAL_RANK_DIMM: 1
BYTE_LANES: 8
TRCD: mtb * 0x69
TRP: mtb * 0x69
TRAS: mtb * 0x118
end
rdimm 52 none
92 11 0C 01 14 10 00 01 0C 52 01 08 0F 00 3C 00 3C 3C 5A 28 3C 2F A0 83
I2C Address: 0x52
START SPD READ
SPD Revision: 1.1
DRAM Type: NOT DDR3!
Module Type: RDIMM
BA_BITS: 4
SDRAM_CAPACITY: 4
ROW_BITS: 14
COL_BITS: 9 
DUAL_RANK_DIMM: 0
TRCD: mtb * 0x5A
TRP: mtb * 0x3C
TRAS: mtb * 0xFA0
end
nack_mid 50 6
92 13 0B 02 04 2A 00 09 03 11 01 08 0C 00 7E 00 69 78 69 30 69 11 18 20
I2C Address: 0x50
START SPD READ
SPD Revision: 1.3
DRAM Type: DDR3 SDRAM
Module Type: UDIMM
BA_BITS: 3
SDRAM_CAPACITY: 4
ROW_BITS: ??
COL_BITS: 11
end
